/* plotter_arc.f */
+incdir+common
+incdir+tests
common/geom_pkg.sv
common/ctrl_pkg.sv
circular_op/quadrant_finder.sv
circular_op/num_steps_calculator.sv
circular_op/arc_stepper.sv
source/step_rate_config.sv
source/circular_op_handler.sv
tests/tb_circular_op_handler.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the arc stepper testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f plotter_arc.f --top-module tb_circular_op_handler \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tests/arc_model.svh */
`ifndef ARC_MODEL_SVH
`define ARC_MODEL_SVH

// Axis points belong to the quadrant that a counter-clockwise walk enters.
function automatic int quadrant_of(input int x, input int y);
	if (x > 0 && y >= 0) return 1;
	if (x <= 0 && y > 0) return 2;
	if (x < 0 && y <= 0) return 3;
	if (y < 0) return 4;
	return 1;
endfunction

// Counter-clockwise distance from (r,0), each quadrant spanning 2r steps.
function automatic int circle_position(input int x, input int y, input int r);
	int ax;
	int ay;
	ax = x < 0 ? -x : x;
	ay = y < 0 ? -y : y;
	case (quadrant_of(x, y))
		1: return (r - ax) + ay;
		2: return 2 * r + ax + (r - ay);
		3: return 4 * r + (r - ax) + ay;
		default: return 6 * r + ax + (r - ay);
	endcase
endfunction

function automatic int expected_steps(input bit cw, input int sx, input int sy,
	input int ex, input int ey, input int r);
	int ccw;
	if (sx == ex && sy == ey) return 0;
	ccw = (circle_position(ex, ey, r) - circle_position(sx, sy, r)) % (8 * r);
	if (ccw < 0) ccw = ccw + 8 * r;
	return cw ? 8 * r - ccw : ccw;
endfunction

// Bit n set when step_dir value n is a legal move (XP, XN, YP, YN).
function automatic bit [3:0] allowed_moves(input int quad, input bit cw);
	bit [3:0] ccw_mask;
	case (quad)
		1: ccw_mask = 4'b0110;
		2: ccw_mask = 4'b1010;
		3: ccw_mask = 4'b1001;
		default: ccw_mask = 4'b0101;
	endcase
	// Clockwise swaps each move for its opposite.
	if (cw) return {ccw_mask[2], ccw_mask[3], ccw_mask[0], ccw_mask[1]};
	return ccw_mask;
endfunction

// One unit step along the stepped circle, nearest squared radius wins.
function automatic void walk_one(input int r, input bit cw, inout int x, inout int y);
	int q;
	int sx;
	int sy;
	int ex;
	int ey;
	q = quadrant_of(x, y);
	sx = (q == 1 || q == 2) ? -1 : 1;
	sy = (q == 2 || q == 3) ? -1 : 1;
	if (cw) begin
		sx = -sx;
		sy = -sy;
	end
	ex = (x + sx) * (x + sx) + y * y - r * r;
	ey = x * x + (y + sy) * (y + sy) - r * r;
	if (ex < 0) ex = -ex;
	if (ey < 0) ey = -ey;
	if (ex <= ey) x = x + sx;
	else y = y + sy;
endfunction

`endif

/* tests/tb_circular_op_handler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arc_defines.svh"
`include "arc_model.svh"

module tb_circular_op_handler;

	localparam int CYCLE_LIMIT = 4000;

	logic clk;
	logic reset;
	logic cmd_valid;
	logic cmd_cw;
	geom_pkg::coord_t cmd_start_x;
	geom_pkg::coord_t cmd_start_y;
	geom_pkg::coord_t cmd_end_x;
	geom_pkg::coord_t cmd_end_y;
	geom_pkg::radius_t cmd_r;
	logic cmd_credit;
	logic cfg_write;
	ctrl_pkg::cfg_addr_t cfg_addr;
	logic [7:0] cfg_data;
	logic step_credit;
	logic step_valid;
	geom_pkg::step_dir_t step_dir;
	logic arc_done;

	int errors = 0;
	int cycle = 0;
	int cmd_credits = `ARC_CMD_DEPTH;
	int credit_pulses = 0;
	int sent = 0;
	int outstanding = 0;
	int step_cnt = 0;
	int dsum_x = 0;
	int dsum_y = 0;
	int gap_min = 0;
	int last_step = -1;
	bit stall = 0;
	bit en_off = 0;

	// Expected arcs in command order.
	string exp_name[$];
	int exp_steps[$];
	int exp_sx[$];
	int exp_sy[$];
	int exp_dx[$];
	int exp_dy[$];
	bit exp_cw[$];

	circular_op_handler DUT (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_cw(cmd_cw),
		.cmd_start_x(cmd_start_x),
		.cmd_start_y(cmd_start_y),
		.cmd_end_x(cmd_end_x),
		.cmd_end_y(cmd_end_y),
		.cmd_r(cmd_r),
		.cmd_credit(cmd_credit),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.step_credit(step_credit),
		.step_valid(step_valid),
		.step_dir(step_dir),
		.arc_done(arc_done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle++;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, arcs still pending: %0d", cycle, exp_steps.size());
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input string what, input int exp, input int act);
		assert (exp == act) else begin
			errors++;
			$display("error %s %s: expected %0d, actual %0d", name, what, exp, act);
		end
	endtask

	// Outputs are sampled on the falling edge, half a cycle after they change.
	always @(negedge clk) begin
		if (!reset) begin
			if (cmd_credit) begin
				cmd_credits++;
				credit_pulses++;
			end
			assert (sent >= credit_pulses) else begin
				errors++;
				$display("Command credits out of balance: %0d sent, %0d returned", sent,
					credit_pulses);
			end
			if (step_valid) begin
				assert (!en_off) else begin
					errors++;
					$display("A step was issued while stepping was disabled");
				end
				assert (outstanding < `ARC_STEP_CREDITS) else begin
					errors++;
					$display("A step was issued with no step credit left");
				end
				if (gap_min > 0 && last_step >= 0) begin
					assert (cycle - last_step >= gap_min) else begin
						errors++;
						$display("error interval step_gap: expected %0d, actual %0d", gap_min,
							cycle - last_step);
					end
				end
				last_step = cycle;
				if (exp_steps.size() > 0) begin
					check_value(exp_name[0], "step_dir_allowed",
						int'(allowed_moves(quadrant_of(exp_sx[0] + dsum_x, exp_sy[0] + dsum_y),
						exp_cw[0])), int'(allowed_moves(quadrant_of(exp_sx[0] + dsum_x,
						exp_sy[0] + dsum_y), exp_cw[0]) | (4'b1 << step_dir)));
				end else begin
					errors++;
					$display("A step was issued with no command outstanding");
				end
				case (step_dir)
					geom_pkg::STEP_XP: dsum_x++;
					geom_pkg::STEP_XN: dsum_x--;
					geom_pkg::STEP_YP: dsum_y++;
					default: dsum_y--;
				endcase
				step_cnt++;
				outstanding++;
			end
			if (step_credit) begin
				outstanding--;
			end
			if (arc_done) begin
				if (exp_steps.size() == 0) begin
					errors++;
					$display("arc_done pulsed with no command outstanding");
				end else begin
					check_value(exp_name[0], "steps", exp_steps[0], step_cnt);
					check_value(exp_name[0], "dx", exp_dx[0], dsum_x);
					check_value(exp_name[0], "dy", exp_dy[0], dsum_y);
					void'(exp_name.pop_front());
					void'(exp_steps.pop_front());
					void'(exp_sx.pop_front());
					void'(exp_sy.pop_front());
					void'(exp_dx.pop_front());
					void'(exp_dy.pop_front());
					void'(exp_cw.pop_front());
				end
				step_cnt = 0;
				dsum_x = 0;
				dsum_y = 0;
			end
		end
	end

	// Driver model returns credits after a random number of cycles.
	initial begin
		step_credit = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			step_credit = !reset && !stall && outstanding > 0 && ($urandom % 3 == 0);
		end
	end

	task automatic send_arc(input string name, input bit cw, input int r, input int k1,
		input int k2);
		int sx;
		int sy;
		int ex;
		int ey;
		sx = r;
		sy = 0;
		for (int i = 0; i < k1; i++) walk_one(r, cw, sx, sy);
		ex = sx;
		ey = sy;
		for (int i = 0; i < k2; i++) walk_one(r, cw, ex, ey);
		@(posedge clk);
		#2;
		while (cmd_credits == 0) begin
			@(posedge clk);
			#2;
		end
		cmd_valid = 1'b1;
		cmd_cw = cw;
		cmd_start_x = geom_pkg::coord_t'(sx);
		cmd_start_y = geom_pkg::coord_t'(sy);
		cmd_end_x = geom_pkg::coord_t'(ex);
		cmd_end_y = geom_pkg::coord_t'(ey);
		cmd_r = geom_pkg::radius_t'(r);
		exp_name.push_back(name);
		exp_steps.push_back(expected_steps(cw, sx, sy, ex, ey, r));
		exp_sx.push_back(sx);
		exp_sy.push_back(sy);
		exp_dx.push_back(ex - sx);
		exp_dy.push_back(ey - sy);
		exp_cw.push_back(cw);
		cmd_credits--;
		sent++;
		@(posedge clk);
		#2;
		cmd_valid = 1'b0;
	endtask

	task automatic write_cfg(input ctrl_pkg::cfg_addr_t addr, input logic [7:0] data);
		@(posedge clk);
		#2;
		cfg_write = 1'b1;
		cfg_addr = addr;
		cfg_data = data;
		@(posedge clk);
		#2;
		cfg_write = 1'b0;
	endtask

	task automatic wait_all_done();
		while (exp_steps.size() > 0) begin
			@(posedge clk);
		end
	endtask

	function automatic int pick_radius();
		return 3 + int'($urandom % 3);
	endfunction

	initial begin
		int r;
		void'($urandom(32'he2d0));
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_cw = 1'b0;
		cmd_start_x = '0;
		cmd_start_y = '0;
		cmd_end_x = '0;
		cmd_end_y = '0;
		cmd_r = '0;
		cfg_write = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;

		r = pick_radius();
		send_arc("same_quadrant", 1'b0, r, 1, 2);
		send_arc("one_axis", 1'b0, r, 2 * r - 1, 3);
		send_arc("several_axes", 1'b1, r, 1, 5 * r);
		send_arc("full_circle_cw", 1'b1, r, 3, 8 * r - 1);
		send_arc("start_is_end", 1'b0, r, r, 0);
		send_arc("start_is_end_cw", 1'b1, r, r + 1, 0);
		wait_all_done();

		// Steps stop at the credit limit while the driver stalls and resume after.
		stall = 1'b1;
		send_arc("credit_stall", $urandom % 2, pick_radius(), 2, 12);
		while (outstanding < `ARC_STEP_CREDITS) @(posedge clk);
		repeat (30) @(posedge clk);
		stall = 1'b0;
		wait_all_done();

		write_cfg(ctrl_pkg::CFG_INTERVAL, 8'd3);
		gap_min = 4;
		last_step = -1;
		send_arc("interval_a", $urandom % 2, pick_radius(), $urandom % 10, 4 + $urandom % 10);
		send_arc("interval_b", $urandom % 2, pick_radius(), $urandom % 10, 4 + $urandom % 10);
		wait_all_done();
		write_cfg(ctrl_pkg::CFG_INTERVAL, 8'd0);
		gap_min = 0;

		write_cfg(ctrl_pkg::CFG_ENABLE, 8'd0);
		repeat (2) @(posedge clk);
		en_off = 1'b1;
		send_arc("enable_gate", $urandom % 2, pick_radius(), $urandom % 10, 5);
		repeat (30) @(posedge clk);
		en_off = 1'b0;
		write_cfg(ctrl_pkg::CFG_ENABLE, 8'd1);
		wait_all_done();

		send_arc("random_a", $urandom % 2, pick_radius(), $urandom % 20, $urandom % 30);
		send_arc("random_b", $urandom % 2, pick_radius(), $urandom % 20, $urandom % 30);
		wait_all_done();
		repeat (10) @(posedge clk);

		check_value("final", "cmd_credit_pulses", sent, credit_pulses);
		$display("Checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule : tb_circular_op_handler

`default_nettype wire

/* source/circular_op_handler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arc_defines.svh"

module circular_op_handler (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input logic cmd_cw,
	input geom_pkg::coord_t cmd_start_x,
	input geom_pkg::coord_t cmd_start_y,
	input geom_pkg::coord_t cmd_end_x,
	input geom_pkg::coord_t cmd_end_y,
	input geom_pkg::radius_t cmd_r,
	output logic cmd_credit,
	input logic cfg_write,
	input ctrl_pkg::cfg_addr_t cfg_addr,
	input logic [7:0] cfg_data,
	input logic step_credit,
	output logic step_valid,
	output geom_pkg::step_dir_t step_dir,
	output logic arc_done
);

	localparam int DEPTH = `ARC_CMD_DEPTH;
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	// Command queue, one array per field.
	logic q_cw [DEPTH];
	geom_pkg::coord_t q_sx [DEPTH];
	geom_pkg::coord_t q_sy [DEPTH];
	geom_pkg::coord_t q_ex [DEPTH];
	geom_pkg::coord_t q_ey [DEPTH];
	geom_pkg::radius_t q_r [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] q_count;

	ctrl_pkg::handler_state_t state;
	logic pop;
	logic stepper_busy;
	logic [7:0] interval;
	logic enable;

	geom_pkg::steps_t calc_steps;
	geom_pkg::steps_t reg_steps;
	geom_pkg::coord_t reg_x;
	geom_pkg::coord_t reg_y;
	geom_pkg::radius_t reg_r;
	logic reg_cw;

	// A new arc leaves the queue while the stepper is free or on its last cycle.
	assign pop = (q_count != '0)
		&& ((state == ctrl_pkg::IDLE) || ((state == ctrl_pkg::BUSY) && arc_done));
	assign cmd_credit = pop;

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			q_cw[wr_ptr] <= cmd_cw;
			q_sx[wr_ptr] <= cmd_start_x;
			q_sy[wr_ptr] <= cmd_start_y;
			q_ex[wr_ptr] <= cmd_end_x;
			q_ey[wr_ptr] <= cmd_end_y;
			q_r[wr_ptr] <= cmd_r;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
			state <= ctrl_pkg::IDLE;
		end else begin
			if (cmd_valid) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (cmd_valid && !pop) begin
				q_count <= q_count + 1'b1;
			end else if (pop && !cmd_valid) begin
				q_count <= q_count - 1'b1;
			end

			case (state)
				ctrl_pkg::IDLE: begin
					if (pop) begin
						state <= ctrl_pkg::LOAD;
					end
				end
				ctrl_pkg::LOAD: begin
					state <= ctrl_pkg::BUSY;
				end
				ctrl_pkg::BUSY: begin
					if (pop) begin
						state <= ctrl_pkg::LOAD;
					end else if (arc_done || !stepper_busy) begin
						state <= ctrl_pkg::IDLE;
					end
				end
				default: begin
					state <= ctrl_pkg::IDLE;
				end
			endcase
		end
	end

	// Count register stage between the calculator and the stepper.
	always_ff @(posedge clk) begin
		if (pop) begin
			reg_steps <= calc_steps;
			reg_x <= q_sx[rd_ptr];
			reg_y <= q_sy[rd_ptr];
			reg_r <= q_r[rd_ptr];
			reg_cw <= q_cw[rd_ptr];
		end
	end

	num_steps_calculator u_num_steps (
		.is_cw(q_cw[rd_ptr]),
		.start_x(q_sx[rd_ptr]),
		.start_y(q_sy[rd_ptr]),
		.end_x(q_ex[rd_ptr]),
		.end_y(q_ey[rd_ptr]),
		.r(q_r[rd_ptr]),
		.num_steps(calc_steps)
	);

	arc_stepper u_stepper (
		.clk(clk),
		.reset(reset),
		.load(state == ctrl_pkg::LOAD),
		.load_cw(reg_cw),
		.load_x(reg_x),
		.load_y(reg_y),
		.load_r(reg_r),
		.load_steps(reg_steps),
		.interval(interval),
		.enable(enable),
		.step_credit(step_credit),
		.step_valid(step_valid),
		.step_dir(step_dir),
		.busy(stepper_busy),
		.arc_done(arc_done)
	);

	step_rate_config u_rate_config (
		.clk(clk),
		.reset(reset),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_data(cfg_data),
		.interval(interval),
		.enable(enable)
	);

endmodule : circular_op_handler

`default_nettype wire

/* source/step_rate_config.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arc_defines.svh"

module step_rate_config (
	input logic clk,
	input logic reset,
	input logic cfg_write,
	input ctrl_pkg::cfg_addr_t cfg_addr,
	input logic [7:0] cfg_data,
	output logic [7:0] interval,
	output logic enable
);

	// Stepping runs right after reset, with the default gap.
	always_ff @(posedge clk) begin
		if (reset) begin
			interval <= 8'(`ARC_RESET_INTERVAL);
			enable <= 1'b1;
		end else if (cfg_write) begin
			case (cfg_addr)
				ctrl_pkg::CFG_INTERVAL: begin
					interval <= cfg_data;
				end
				ctrl_pkg::CFG_ENABLE: begin
					enable <= cfg_data[0];
				end
				default: begin
					// Unmapped address.
				end
			endcase
		end
	end

endmodule : step_rate_config

`default_nettype wire

/* circular_op/arc_stepper.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arc_defines.svh"

module arc_stepper (
	input logic clk,
	input logic reset,
	input logic load,
	input logic load_cw,
	input geom_pkg::coord_t load_x,
	input geom_pkg::coord_t load_y,
	input geom_pkg::radius_t load_r,
	input geom_pkg::steps_t load_steps,
	input logic [7:0] interval,
	input logic enable,
	input logic step_credit,
	output logic step_valid,
	output geom_pkg::step_dir_t step_dir,
	output logic busy,
	output logic arc_done
);

	localparam int CREDIT_BITS = $clog2(`ARC_STEP_CREDITS + 1);
	localparam int SQ_BITS = 2 * $bits(geom_pkg::coord_t) + 4;

	ctrl_pkg::stepper_state_t state;
	logic [CREDIT_BITS-1:0] credit_cnt;
	logic [7:0] gap_cnt;
	geom_pkg::steps_t remaining;

	geom_pkg::coord_t cur_x;
	geom_pkg::coord_t cur_y;
	geom_pkg::radius_t cur_r;
	logic cur_cw;

	geom_pkg::quadrant_t cur_quadrant;
	logic x_neg;
	logic y_neg;
	geom_pkg::coord_t next_x;
	geom_pkg::coord_t next_y;
	logic use_x;

	// Distance of a point's squared radius from r squared.
	function automatic logic [SQ_BITS-1:0] radius_error(
		input geom_pkg::coord_t x,
		input geom_pkg::coord_t y,
		input geom_pkg::radius_t r
	);
		logic signed [SQ_BITS-1:0] xs;
		logic signed [SQ_BITS-1:0] ys;
		logic signed [SQ_BITS-1:0] rs;
		logic signed [SQ_BITS-1:0] diff;
		xs = x;
		ys = y;
		rs = r;
		diff = xs * xs + ys * ys - rs * rs;
		return diff < 0 ? -diff : diff;
	endfunction

	quadrant_finder u_cur_quadrant (
		.relative_x(cur_x),
		.relative_y(cur_y),
		.quadrant(cur_quadrant)
	);

	// Counter-clockwise moves per quadrant; clockwise takes the opposite of both.
	assign x_neg = ((cur_quadrant == geom_pkg::QUAD_1) || (cur_quadrant == geom_pkg::QUAD_2)) ^ cur_cw;
	assign y_neg = ((cur_quadrant == geom_pkg::QUAD_2) || (cur_quadrant == geom_pkg::QUAD_3)) ^ cur_cw;

	assign next_x = x_neg ? cur_x - 1'b1 : cur_x + 1'b1;
	assign next_y = y_neg ? cur_y - 1'b1 : cur_y + 1'b1;

	assign use_x = radius_error(next_x, cur_y, cur_r) <= radius_error(cur_x, next_y, cur_r);

	assign step_dir = use_x
		? (x_neg ? geom_pkg::STEP_XN : geom_pkg::STEP_XP)
		: (y_neg ? geom_pkg::STEP_YN : geom_pkg::STEP_YP);

	assign step_valid = (state == ctrl_pkg::ISSUE) && (remaining != '0) && (credit_cnt != '0) && enable;
	assign arc_done = (state == ctrl_pkg::ISSUE)
		&& ((remaining == '0) || (step_valid && (remaining == geom_pkg::steps_t'(1))));
	assign busy = state != ctrl_pkg::ST_IDLE;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrl_pkg::ST_IDLE;
			credit_cnt <= CREDIT_BITS'(`ARC_STEP_CREDITS);
			gap_cnt <= '0;
			remaining <= '0;
		end else begin
			// Returned credit and issued step in one cycle cancel.
			if (step_valid && !step_credit) begin
				credit_cnt <= credit_cnt - 1'b1;
			end else if (step_credit && !step_valid) begin
				credit_cnt <= credit_cnt + 1'b1;
			end

			case (state)
				ctrl_pkg::ST_IDLE: begin
					if (load) begin
						remaining <= load_steps;
						if ((load_steps == '0) || (interval == '0)) begin
							state <= ctrl_pkg::ISSUE;
						end else begin
							gap_cnt <= interval - 1'b1;
							state <= ctrl_pkg::WAIT_GAP;
						end
					end
				end
				ctrl_pkg::WAIT_GAP: begin
					if (gap_cnt == '0) begin
						state <= ctrl_pkg::ISSUE;
					end else begin
						gap_cnt <= gap_cnt - 1'b1;
					end
				end
				ctrl_pkg::ISSUE: begin
					if (arc_done) begin
						state <= ctrl_pkg::ST_IDLE;
					end else if (step_valid) begin
						remaining <= remaining - 1'b1;
						if (interval != '0) begin
							gap_cnt <= interval - 1'b1;
							state <= ctrl_pkg::WAIT_GAP;
						end
					end
				end
				default: begin
					state <= ctrl_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// Current point follows each issued step.
	always_ff @(posedge clk) begin
		if ((state == ctrl_pkg::ST_IDLE) && load) begin
			cur_x <= load_x;
			cur_y <= load_y;
			cur_r <= load_r;
			cur_cw <= load_cw;
		end else if (step_valid) begin
			if (use_x) begin
				cur_x <= next_x;
			end else begin
				cur_y <= next_y;
			end
		end
	end

endmodule : arc_stepper

`default_nettype wire

/* circular_op/num_steps_calculator.sv */
`timescale 1ns/1ps
`default_nettype none

module num_steps_calculator (
	input logic is_cw,
	input geom_pkg::coord_t start_x,
	input geom_pkg::coord_t start_y,
	input geom_pkg::coord_t end_x,
	input geom_pkg::coord_t end_y,
	input geom_pkg::radius_t r,
	output geom_pkg::steps_t num_steps
);

	localparam int STEP_BITS = $bits(geom_pkg::steps_t);

	// Sign-extended copies, wide enough for differences without overflow.
	logic signed [STEP_BITS-1:0] sx_w;
	logic signed [STEP_BITS-1:0] sy_w;
	logic signed [STEP_BITS-1:0] ex_w;
	logic signed [STEP_BITS-1:0] ey_w;

	geom_pkg::steps_t abs_sx;
	geom_pkg::steps_t abs_sy;
	geom_pkg::steps_t abs_ex;
	geom_pkg::steps_t abs_ey;
	geom_pkg::steps_t abs_dx;
	geom_pkg::steps_t abs_dy;
	geom_pkg::steps_t r_ext;

	geom_pkg::quadrant_t start_quadrant;
	geom_pkg::quadrant_t end_quadrant;

	logic is_crossing;
	logic same_point;
	logic [1:0] quadrants_passed;
	geom_pkg::steps_t full_quadrant_steps;
	geom_pkg::steps_t start_to_axis_steps;
	geom_pkg::steps_t axis_to_end_steps;
	geom_pkg::steps_t steps_ccw;
	geom_pkg::steps_t steps_cw;

	function automatic geom_pkg::steps_t abs_wide(input logic signed [STEP_BITS-1:0] value);
		return value < 0 ? geom_pkg::steps_t'(-value) : geom_pkg::steps_t'(value);
	endfunction

	quadrant_finder u_start_quadrant (
		.relative_x(start_x),
		.relative_y(start_y),
		.quadrant(start_quadrant)
	);

	quadrant_finder u_end_quadrant (
		.relative_x(end_x),
		.relative_y(end_y),
		.quadrant(end_quadrant)
	);

	assign sx_w = start_x;
	assign sy_w = start_y;
	assign ex_w = end_x;
	assign ey_w = end_y;
	assign r_ext = geom_pkg::steps_t'(r);

	assign abs_sx = abs_wide(sx_w);
	assign abs_sy = abs_wide(sy_w);
	assign abs_ex = abs_wide(ex_w);
	assign abs_ey = abs_wide(ey_w);
	assign abs_dx = abs_wide(ex_w - sx_w);
	assign abs_dy = abs_wide(ey_w - sy_w);

	assign same_point = (start_x == end_x) && (start_y == end_y);

	// Counter-clockwise, |x| falls and |y| rises in quadrants 1 and 3, the reverse in 2 and 4.
	// An end point behind the start inside one quadrant means going all the way round.
	always_comb begin
		is_crossing = 1'b1;
		if (start_quadrant == end_quadrant) begin
			if (start_quadrant == geom_pkg::QUAD_1 || start_quadrant == geom_pkg::QUAD_3) begin
				is_crossing = (abs_ex > abs_sx) || (abs_ey < abs_sy);
			end else begin
				is_crossing = (abs_ex < abs_sx) || (abs_ey > abs_sy);
			end
		end
	end

	// Modulo 4, so equal quadrants with a crossing give three full quadrants.
	assign quadrants_passed = 2'(end_quadrant - start_quadrant - 1);
	assign full_quadrant_steps = geom_pkg::steps_t'(quadrants_passed) * (r_ext << 1);

	// Manhattan distance from the start to the axis that closes its quadrant.
	always_comb begin
		case (start_quadrant)
			geom_pkg::QUAD_1, geom_pkg::QUAD_3: begin
				start_to_axis_steps = abs_sx - abs_sy + r_ext;
			end
			default: begin
				start_to_axis_steps = r_ext - abs_sx + abs_sy;
			end
		endcase
	end

	// Manhattan distance from the axis that opens the end quadrant.
	always_comb begin
		case (end_quadrant)
			geom_pkg::QUAD_1, geom_pkg::QUAD_3: begin
				axis_to_end_steps = r_ext - abs_ex + abs_ey;
			end
			default: begin
				axis_to_end_steps = abs_ex - abs_ey + r_ext;
			end
		endcase
	end

	assign steps_ccw = is_crossing
		? (full_quadrant_steps + start_to_axis_steps + axis_to_end_steps)
		: (abs_dx + abs_dy);

	// Clockwise covers the rest of the 8r circle.
	assign steps_cw = same_point ? '0 : ((r_ext << 3) - steps_ccw);

	assign num_steps = is_cw ? steps_cw : steps_ccw;

endmodule : num_steps_calculator

`default_nettype wire

/* circular_op/quadrant_finder.sv */
`timescale 1ns/1ps
`default_nettype none

module quadrant_finder (
	input geom_pkg::coord_t relative_x,
	input geom_pkg::coord_t relative_y,
	output geom_pkg::quadrant_t quadrant
);

	logic x_neg;
	logic y_neg;
	logic x_zero;
	logic y_zero;

	assign x_neg = relative_x < 0;
	assign y_neg = relative_y < 0;
	assign x_zero = relative_x == '0;
	assign y_zero = relative_y == '0;

	// Each half-open quadrant owns the axis where a counter-clockwise walk enters it.
	always_comb begin
		if (!x_neg && !x_zero && !y_neg) begin
			quadrant = geom_pkg::QUAD_1;
		end else if ((x_neg || x_zero) && !y_neg && !y_zero) begin
			quadrant = geom_pkg::QUAD_2;
		end else if (x_neg && (y_neg || y_zero)) begin
			quadrant = geom_pkg::QUAD_3;
		end else if (y_neg) begin
			quadrant = geom_pkg::QUAD_4;
		end else begin
			// The center itself.
			quadrant = geom_pkg::QUAD_1;
		end
	end

endmodule : quadrant_finder

`default_nettype wire

/* common/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		BUSY
	} handler_state_t;

	// Prefixed idle state, the handler enum already owns IDLE.
	typedef enum logic [1:0] {
		ST_IDLE,
		WAIT_GAP,
		ISSUE
	} stepper_state_t;

	typedef logic [1:0] cfg_addr_t;

	localparam cfg_addr_t CFG_INTERVAL = 2'd0;
	localparam cfg_addr_t CFG_ENABLE = 2'd1;

endpackage : ctrl_pkg

`default_nettype wire

/* common/geom_pkg.sv */
`default_nettype none

`include "arc_defines.svh"

package geom_pkg;

	// Coordinates are relative to the arc center.
	typedef logic signed [`ARC_NUM_BITS-1:0] coord_t;

	typedef logic [`ARC_NUM_BITS-1:0] radius_t;

	typedef logic [`ARC_STEP_BITS-1:0] steps_t;

	// Axis points go to the quadrant that starts at that axis (counter-clockwise).
	typedef enum logic [1:0] {
		QUAD_1 = 2'd0,
		QUAD_2 = 2'd1,
		QUAD_3 = 2'd2,
		QUAD_4 = 2'd3
	} quadrant_t;

	// Single-axis unit moves.
	typedef enum logic [1:0] {
		STEP_XP = 2'd0,
		STEP_XN = 2'd1,
		STEP_YP = 2'd2,
		STEP_YN = 2'd3
	} step_dir_t;

endpackage : geom_pkg

`default_nettype wire

/* common/arc_defines.svh */
`ifndef ARC_DEFINES_SVH
`define ARC_DEFINES_SVH

// Width of a signed coordinate and of the radius.
`define ARC_NUM_BITS 8

// A full circle takes 8r steps, so three extra bits.
`define ARC_STEP_BITS (`ARC_NUM_BITS + 3)

// Command queue entries, equal to the credits the source starts with.
`define ARC_CMD_DEPTH 2

// Step credits held by the stepper after reset.
`define ARC_STEP_CREDITS 4

`define ARC_RESET_INTERVAL 0

`endif
